// File: verilog/axi_nes_settings.svh
// Bus widths, register offsets, control and status bit positions, version fields
`ifndef AXI_NES_SETTINGS_SVH
`define AXI_NES_SETTINGS_SVH

// AXI4-Lite bus sizes
`define AXI_ADDR_WIDTH          18
`define AXI_DATA_WIDTH          32
`define AXI_STRB_WIDTH          4

// Register byte offsets
`define REG_CONTROL_ADDR        18'h00000
`define REG_STATUS_ADDR         18'h00004
`define REG_VERSION_ADDR        18'h10000

// CONTROL bits
`define CTL_BIT_ENABLE          0
`define CTL_BIT_RGBA_FMT        1
`define CTL_BIT_LOADER_RESET    4

// STATUS bits
`define STS_BIT_ROM_LOADED      4

// Version word layout
`define VERSION_MAJOR           4'd1
`define VERSION_MINOR           8'd0
`define VERSION_REVISION        4'd0
`define VERSION_MAJOR_RANGE     31:28
`define VERSION_MINOR_RANGE     27:20
`define VERSION_REVISION_RANGE  19:16

// Response codes
`define AXI_RESP_OKAY           2'b00
`define AXI_RESP_SLVERR         2'b10

`endif

// File: verilog/axi_nes_pkg.sv
// Register access structs plus slave state and register address enums
`default_nettype none
`include "axi_nes_settings.svh"

package axi_nes_pkg;

  // One register access, valid is a single-cycle strobe
  typedef struct packed {
    logic                        valid;
    logic                        write;
    logic [`AXI_ADDR_WIDTH-1:0]  addr;
    logic [`AXI_DATA_WIDTH-1:0]  wdata;
    logic [`AXI_STRB_WIDTH-1:0]  wstrb;
  } reg_req_t;

  // Answer to one access
  typedef struct packed {
    logic                        valid;
    logic                        invalid;
    logic [`AXI_DATA_WIDTH-1:0]  rdata;
  } reg_resp_t;

  // Bus side sequencing
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_REG,
    ST_WRITE_RESP,
    ST_READ_RESP
  } slave_state_e;

  // Decoded register map
  typedef enum logic [`AXI_ADDR_WIDTH-1:0] {
    REG_CONTROL = `REG_CONTROL_ADDR,
    REG_STATUS  = `REG_STATUS_ADDR,
    REG_VERSION = `REG_VERSION_ADDR
  } reg_addr_e;

endpackage

`default_nettype wire

// File: verilog/axi_lite_reg_slave.sv
// AXI4-Lite slave that turns bus transactions into single register accesses
`timescale 1ns/1ns
`default_nettype none
`include "axi_nes_settings.svh"

module axi_lite_reg_slave
  import axi_nes_pkg::*;
(
  input  wire                         i_axi_clk,
  input  wire                         w_axi_rst,

  // Write address
  input  wire                         i_awvalid,
  input  wire [`AXI_ADDR_WIDTH-1:0]   i_awaddr,
  output logic                        o_awready,

  // Write data
  input  wire                         i_wvalid,
  input  wire [`AXI_STRB_WIDTH-1:0]   i_wstrb,
  input  wire [`AXI_DATA_WIDTH-1:0]   i_wdata,
  output logic                        o_wready,

  // Write response
  output logic                        o_bvalid,
  input  wire                         i_bready,
  output logic [1:0]                  o_bresp,

  // Read address
  input  wire                         i_arvalid,
  input  wire [`AXI_ADDR_WIDTH-1:0]   i_araddr,
  output logic                        o_arready,

  // Read data
  output logic                        o_rvalid,
  input  wire                         i_rready,
  output logic [1:0]                  o_rresp,
  output logic [`AXI_DATA_WIDTH-1:0]  o_rdata,

  // Register side
  output reg_req_t                    o_reg_req,
  input  wire reg_resp_t              i_reg_resp
);

  slave_state_e                 r_state;
  logic                         w_wr_accept;
  logic                         w_rd_accept;
  logic                         w_resp_done;
  logic [1:0]                   w_resp_code;

  logic                         r_req_valid;
  logic                         r_req_write;
  logic [`AXI_ADDR_WIDTH-1:0]   r_req_addr;
  logic [`AXI_DATA_WIDTH-1:0]   r_req_wdata;
  logic [`AXI_STRB_WIDTH-1:0]   r_req_wstrb;

  // Write needs address and data together, and beats a read
  assign w_wr_accept = (r_state == ST_IDLE) && i_awvalid && i_wvalid;
  assign w_rd_accept = (r_state == ST_IDLE) && i_arvalid && !(i_awvalid && i_wvalid);

  assign o_awready   = w_wr_accept;
  assign o_wready    = w_wr_accept;
  assign o_arready   = w_rd_accept;

  assign w_resp_done = (r_state == ST_WAIT_REG) && i_reg_resp.valid;
  assign w_resp_code = i_reg_resp.invalid ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;

  assign o_reg_req = '{
    valid: r_req_valid,
    write: r_req_write,
    addr:  r_req_addr,
    wdata: r_req_wdata,
    wstrb: r_req_wstrb
  };

  always_ff @(posedge i_axi_clk) begin
    if (w_axi_rst) begin
      r_state     <= ST_IDLE;
      r_req_valid <= 1'b0;
      o_bvalid    <= 1'b0;
      o_rvalid    <= 1'b0;
    end else begin
      // Strobe lands one cycle after the address handshake
      r_req_valid <= w_wr_accept || w_rd_accept;
      case (r_state)
        ST_IDLE: begin
          if (w_wr_accept || w_rd_accept) begin
            r_state <= ST_WAIT_REG;
          end
        end
        ST_WAIT_REG: begin
          if (i_reg_resp.valid) begin
            if (r_req_write) begin
              o_bvalid <= 1'b1;
              r_state  <= ST_WRITE_RESP;
            end else begin
              o_rvalid <= 1'b1;
              r_state  <= ST_READ_RESP;
            end
          end
        end
        ST_WRITE_RESP: begin
          if (i_bready) begin
            o_bvalid <= 1'b0;
            r_state  <= ST_IDLE;
          end
        end
        ST_READ_RESP: begin
          if (i_rready) begin
            o_rvalid <= 1'b0;
            r_state  <= ST_IDLE;
          end
        end
        default: begin
          r_state <= ST_IDLE;
        end
      endcase
    end
  end

  // Captured request and held response payload
  always_ff @(posedge i_axi_clk) begin
    if (w_wr_accept) begin
      r_req_write <= 1'b1;
      r_req_addr  <= i_awaddr;
      r_req_wdata <= i_wdata;
      r_req_wstrb <= i_wstrb;
    end else if (w_rd_accept) begin
      r_req_write <= 1'b0;
      r_req_addr  <= i_araddr;
      r_req_wstrb <= '0;
    end
    if (w_resp_done) begin
      if (r_req_write) begin
        o_bresp <= w_resp_code;
      end else begin
        o_rresp <= w_resp_code;
        o_rdata <= i_reg_resp.rdata;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/nes_ctrl_regs.sv
// Control, status and version registers with address decode and loader reset pulse
`timescale 1ns/1ns
`default_nettype none
`include "axi_nes_settings.svh"

module nes_ctrl_regs
  import axi_nes_pkg::*;
(
  input  wire                i_axi_clk,
  input  wire                w_axi_rst,

  input  wire reg_req_t      i_reg_req,
  input  wire                i_rom_loaded,
  output reg_resp_t          o_reg_resp,

  output logic               o_core_enable,
  output logic               o_rgba_fmt,
  output logic               o_loader_rst
);

  reg_addr_e                    w_addr;
  logic                         w_invalid;
  logic                         w_ctl_sel;
  logic                         w_ctl_wr;
  logic [`AXI_DATA_WIDTH-1:0]   w_rdata;
  logic [`AXI_DATA_WIDTH-1:0]   w_version;

  logic [`AXI_DATA_WIDTH-1:0]   r_control;
  logic                         r_resp_valid;
  logic                         r_invalid;
  logic [`AXI_DATA_WIDTH-1:0]   r_rdata;

  assign w_addr = reg_addr_e'(i_reg_req.addr);

  always_comb begin
    w_version                          = '0;
    w_version[`VERSION_MAJOR_RANGE]    = `VERSION_MAJOR;
    w_version[`VERSION_MINOR_RANGE]    = `VERSION_MINOR;
    w_version[`VERSION_REVISION_RANGE] = `VERSION_REVISION;
  end

  // Address decode and read mux
  always_comb begin
    w_rdata   = '0;
    w_invalid = 1'b0;
    w_ctl_sel = 1'b0;
    case (w_addr)
      REG_CONTROL: begin
        w_ctl_sel = 1'b1;
        w_rdata   = r_control;
      end
      REG_STATUS: begin
        w_rdata[`STS_BIT_ROM_LOADED] = i_rom_loaded;
      end
      REG_VERSION: begin
        w_rdata = w_version;
      end
      default: begin
        w_invalid = 1'b1;
      end
    endcase
  end

  assign w_ctl_wr = i_reg_req.valid && i_reg_req.write && w_ctl_sel;

  always_ff @(posedge i_axi_clk) begin
    if (w_axi_rst) begin
      r_control    <= '0;
      r_resp_valid <= 1'b0;
      o_loader_rst <= 1'b0;
    end else begin
      r_resp_valid <= i_reg_req.valid;
      // Pulse only when the byte holding the bit is strobed
      o_loader_rst <= w_ctl_wr
                      && i_reg_req.wdata[`CTL_BIT_LOADER_RESET]
                      && i_reg_req.wstrb[`CTL_BIT_LOADER_RESET / 8];
      for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
        if (w_ctl_wr && i_reg_req.wstrb[i]) begin
          r_control[i*8 +: 8] <= i_reg_req.wdata[i*8 +: 8];
        end
      end
    end
  end

  // Response payload, undecoded reads return zero
  always_ff @(posedge i_axi_clk) begin
    if (i_reg_req.valid) begin
      r_invalid <= w_invalid;
      r_rdata   <= w_rdata;
    end
  end

  assign o_reg_resp = '{
    valid:   r_resp_valid,
    invalid: r_invalid,
    rdata:   r_rdata
  };

  assign o_core_enable = r_control[`CTL_BIT_ENABLE];
  assign o_rgba_fmt    = r_control[`CTL_BIT_RGBA_FMT];

endmodule

`default_nettype wire

// File: verilog/axi_nes.sv
// Console control top with reset polarity select, AXI4-Lite slave and register block
`timescale 1ns/1ns
`default_nettype none
`include "axi_nes_settings.svh"

module axi_nes
  import axi_nes_pkg::*;
#(
  parameter bit INVERT_AXI_RESET = 1'b1
) (
  input  wire                         i_axi_clk,
  input  wire                         i_axi_rst,
  input  wire                         i_rom_loaded,

  input  wire                         i_awvalid,
  input  wire [`AXI_ADDR_WIDTH-1:0]   i_awaddr,
  output wire                         o_awready,

  input  wire                         i_wvalid,
  input  wire [`AXI_STRB_WIDTH-1:0]   i_wstrb,
  input  wire [`AXI_DATA_WIDTH-1:0]   i_wdata,
  output wire                         o_wready,

  output wire                         o_bvalid,
  input  wire                         i_bready,
  output wire [1:0]                   o_bresp,

  input  wire                         i_arvalid,
  input  wire [`AXI_ADDR_WIDTH-1:0]   i_araddr,
  output wire                         o_arready,

  output wire                         o_rvalid,
  input  wire                         i_rready,
  output wire [1:0]                   o_rresp,
  output wire [`AXI_DATA_WIDTH-1:0]   o_rdata,

  output wire                         o_core_enable,
  output wire                         o_rgba_fmt,
  output wire                         o_loader_rst
);

  wire             w_axi_rst;
  wire reg_req_t   w_reg_req;
  wire reg_resp_t  w_reg_resp;

  // Active low reset from the host side by default
  assign w_axi_rst = INVERT_AXI_RESET ? ~i_axi_rst : i_axi_rst;

  axi_lite_reg_slave slave0 (
    .i_axi_clk  (i_axi_clk),
    .w_axi_rst  (w_axi_rst),
    .i_awvalid  (i_awvalid),
    .i_awaddr   (i_awaddr),
    .o_awready  (o_awready),
    .i_wvalid   (i_wvalid),
    .i_wstrb    (i_wstrb),
    .i_wdata    (i_wdata),
    .o_wready   (o_wready),
    .o_bvalid   (o_bvalid),
    .i_bready   (i_bready),
    .o_bresp    (o_bresp),
    .i_arvalid  (i_arvalid),
    .i_araddr   (i_araddr),
    .o_arready  (o_arready),
    .o_rvalid   (o_rvalid),
    .i_rready   (i_rready),
    .o_rresp    (o_rresp),
    .o_rdata    (o_rdata),
    .o_reg_req  (w_reg_req),
    .i_reg_resp (w_reg_resp)
  );

  nes_ctrl_regs regs0 (
    .i_axi_clk     (i_axi_clk),
    .w_axi_rst     (w_axi_rst),
    .i_reg_req     (w_reg_req),
    .i_rom_loaded  (i_rom_loaded),
    .o_reg_resp    (w_reg_resp),
    .o_core_enable (o_core_enable),
    .o_rgba_fmt    (o_rgba_fmt),
    .o_loader_rst  (o_loader_rst)
  );

endmodule

`default_nettype wire

// File: test/axi_nes_checker.sv
// Bound assertions for response holding, loader reset pulse width and reset behaviour
`timescale 1ns/1ns
`default_nettype none
`include "axi_nes_settings.svh"

module axi_nes_checker (
  input wire                        i_axi_clk,
  input wire                        w_axi_rst,
  input wire                        i_bvalid,
  input wire                        i_bready,
  input wire [1:0]                  i_bresp,
  input wire                        i_rvalid,
  input wire                        i_rready,
  input wire [1:0]                  i_rresp,
  input wire [`AXI_DATA_WIDTH-1:0]  i_rdata,
  input wire                        i_loader_rst
);

  // Write response waits for the master
  a_b_hold: assert property (@(posedge i_axi_clk) disable iff (w_axi_rst)
    i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
    else $error("write response dropped or changed before bready");

  // Read data and response wait for the master
  a_r_hold: assert property (@(posedge i_axi_clk) disable iff (w_axi_rst)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp))
    else $error("read response dropped or changed before rready");

  a_pulse_width: assert property (@(posedge i_axi_clk) disable iff (w_axi_rst)
    i_loader_rst |=> !i_loader_rst)
    else $error("loader reset high for more than one cycle");

  // Responses cleared by reset
  a_rst_quiet: assert property (@(posedge i_axi_clk)
    w_axi_rst |=> !i_bvalid && !i_rvalid)
    else $error("response valid while in reset");

endmodule

bind axi_nes axi_nes_checker chk0 (
  .i_axi_clk    (i_axi_clk),
  .w_axi_rst    (w_axi_rst),
  .i_bvalid     (o_bvalid),
  .i_bready     (i_bready),
  .i_bresp      (o_bresp),
  .i_rvalid     (o_rvalid),
  .i_rready     (i_rready),
  .i_rresp      (o_rresp),
  .i_rdata      (o_rdata),
  .i_loader_rst (o_loader_rst)
);

`default_nettype wire

// File: test/tb_axi_nes.sv
// Directed testbench for the console control block with AXI4-Lite bus tasks and tests
`timescale 1ns/1ns
`default_nettype none
`include "axi_nes_settings.svh"

module tb_axi_nes;

  // About 25 transactions of at most 20 cycles each, plus reset, with a wide margin
  localparam int TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] VERSION_WORD = 32'h1000_0000;
  localparam logic [`AXI_ADDR_WIDTH-1:0] BAD_ADDR = 18'h00008;

  logic clk;
  logic rst_n;
  logic rom_loaded;
  logic awvalid;
  logic [`AXI_ADDR_WIDTH-1:0] awaddr;
  logic wvalid;
  logic [`AXI_STRB_WIDTH-1:0] wstrb;
  logic [`AXI_DATA_WIDTH-1:0] wdata;
  logic bready;
  logic arvalid;
  logic [`AXI_ADDR_WIDTH-1:0] araddr;
  logic rready;
  wire o_awready;
  wire o_wready;
  wire o_bvalid;
  wire [1:0] o_bresp;
  wire o_arready;
  wire o_rvalid;
  wire [1:0] o_rresp;
  wire [`AXI_DATA_WIDTH-1:0] o_rdata;
  wire o_core_enable;
  wire o_rgba_fmt;
  wire o_loader_rst;

  int seed;
  int cycles = 0;
  int test_errors = 0;
  int total_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int pulse_cnt = 0;
  int pulses_at_b = 0;
  logic [31:0] ctl_model;

  axi_nes #(.INVERT_AXI_RESET(1'b1)) dut0 (
    .i_axi_clk(clk), .i_axi_rst(rst_n), .i_rom_loaded(rom_loaded),
    .i_awvalid(awvalid), .i_awaddr(awaddr), .o_awready(o_awready),
    .i_wvalid(wvalid), .i_wstrb(wstrb), .i_wdata(wdata), .o_wready(o_wready),
    .o_bvalid(o_bvalid), .i_bready(bready), .o_bresp(o_bresp),
    .i_arvalid(arvalid), .i_araddr(araddr), .o_arready(o_arready),
    .o_rvalid(o_rvalid), .i_rready(rready), .o_rresp(o_rresp), .o_rdata(o_rdata),
    .o_core_enable(o_core_enable), .o_rgba_fmt(o_rgba_fmt), .o_loader_rst(o_loader_rst)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  // Count loader reset pulses in the middle of each cycle
  always @(negedge clk) begin
    if (o_loader_rst === 1'b1) begin
      pulse_cnt <= pulse_cnt + 1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
      test_errors++;
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[i*8 +: 8] = new_val[i*8 +: 8];
    end
    return res;
  endfunction

  task automatic axi_write(input logic [`AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int delay, output logic [1:0] resp);
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    do @(negedge clk); while (!(o_awready && o_wready));
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(negedge clk); while (!o_bvalid);
    resp = o_bresp;
    pulses_at_b = pulse_cnt;
    repeat (delay) begin
      @(negedge clk);
      check_value("o_bvalid", o_bvalid, 1);
      check_value("o_bresp", o_bresp, resp);
    end
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [`AXI_ADDR_WIDTH-1:0] addr, input int delay,
                          output logic [31:0] data, output logic [1:0] resp);
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    do @(negedge clk); while (!o_arready);
    @(posedge clk);
    arvalid <= 1'b0;
    do @(negedge clk); while (!o_rvalid);
    data = o_rdata;
    resp = o_rresp;
    repeat (delay) begin
      @(negedge clk);
      check_value("o_rvalid", o_rvalid, 1);
      check_value("o_rdata", o_rdata, data);
      check_value("o_rresp", o_rresp, resp);
    end
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic read_expect(input logic [`AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] exp,
                             input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0] resp;
    axi_read(addr, 0, data, resp);
    check_value("o_rdata", data, exp);
    check_value("o_rresp", resp, exp_resp);
  endtask

  task automatic write_expect(input logic [`AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic [1:0] exp_resp);
    logic [1:0] resp;
    axi_write(addr, data, strb, 0, resp);
    check_value("o_bresp", resp, exp_resp);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s passed", name);
    end else begin
      $display("test %s failed with %0d errors", name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  task automatic test_reset_values();
    read_expect(`REG_CONTROL_ADDR, 32'h0, `AXI_RESP_OKAY);
    read_expect(`REG_VERSION_ADDR, VERSION_WORD, `AXI_RESP_OKAY);
    check_value("o_core_enable", o_core_enable, 0);
    check_value("o_rgba_fmt", o_rgba_fmt, 0);
  endtask

  task automatic test_control_rw();
    logic [31:0] data;
    logic [3:0] strb;
    data = $random(seed);
    write_expect(`REG_CONTROL_ADDR, data, 4'hf, `AXI_RESP_OKAY);
    ctl_model = data;
    read_expect(`REG_CONTROL_ADDR, ctl_model, `AXI_RESP_OKAY);
    check_value("o_core_enable", o_core_enable, ctl_model[0]);
    check_value("o_rgba_fmt", o_rgba_fmt, ctl_model[1]);
    data = $random(seed);
    strb = 4'b0101;
    write_expect(`REG_CONTROL_ADDR, data, strb, `AXI_RESP_OKAY);
    ctl_model = merge_bytes(ctl_model, data, strb);
    read_expect(`REG_CONTROL_ADDR, ctl_model, `AXI_RESP_OKAY);
    check_value("o_core_enable", o_core_enable, ctl_model[0]);
    check_value("o_rgba_fmt", o_rgba_fmt, ctl_model[1]);
  endtask

  task automatic test_loader_pulse();
    int base;
    base = pulse_cnt;
    write_expect(`REG_CONTROL_ADDR, 32'h10, 4'hf, `AXI_RESP_OKAY);
    check_value("o_loader_rst pulses before bvalid", pulses_at_b - base, 1);
    check_value("o_loader_rst pulses", pulse_cnt - base, 1);
    base = pulse_cnt;
    write_expect(`REG_CONTROL_ADDR, 32'h03, 4'hf, `AXI_RESP_OKAY);
    check_value("o_loader_rst pulses", pulse_cnt - base, 0);
    // Bit 4 set but its byte lane not strobed
    write_expect(`REG_CONTROL_ADDR, 32'h10, 4'b1110, `AXI_RESP_OKAY);
    check_value("o_loader_rst pulses", pulse_cnt - base, 0);
    ctl_model = merge_bytes(32'h03, 32'h10, 4'b1110);
  endtask

  task automatic test_status_version();
    @(posedge clk);
    rom_loaded <= 1'b1;
    read_expect(`REG_STATUS_ADDR, 32'h10, `AXI_RESP_OKAY);
    @(posedge clk);
    rom_loaded <= 1'b0;
    read_expect(`REG_STATUS_ADDR, 32'h0, `AXI_RESP_OKAY);
    write_expect(`REG_STATUS_ADDR, $random(seed), 4'hf, `AXI_RESP_OKAY);
    read_expect(`REG_STATUS_ADDR, 32'h0, `AXI_RESP_OKAY);
    write_expect(`REG_VERSION_ADDR, $random(seed), 4'hf, `AXI_RESP_OKAY);
    read_expect(`REG_VERSION_ADDR, VERSION_WORD, `AXI_RESP_OKAY);
  endtask

  task automatic test_bad_address();
    write_expect(BAD_ADDR, $random(seed), 4'hf, `AXI_RESP_SLVERR);
    read_expect(BAD_ADDR, 32'h0, `AXI_RESP_SLVERR);
    read_expect(`REG_CONTROL_ADDR, ctl_model, `AXI_RESP_OKAY);
  endtask

  task automatic test_backpressure();
    logic [31:0] data;
    logic [1:0] resp;
    int delay;
    data = $random(seed);
    delay = 1 + ($unsigned($random(seed)) % 8);
    axi_write(`REG_CONTROL_ADDR, data, 4'hf, delay, resp);
    check_value("o_bresp", resp, `AXI_RESP_OKAY);
    ctl_model = data;
    delay = 1 + ($unsigned($random(seed)) % 8);
    axi_read(`REG_CONTROL_ADDR, delay, data, resp);
    check_value("o_rdata", data, ctl_model);
    check_value("o_rresp", resp, `AXI_RESP_OKAY);
    read_expect(`REG_VERSION_ADDR, VERSION_WORD, `AXI_RESP_OKAY);
  endtask

  initial begin
    seed = 37606;
    ctl_model = 32'h0;
    rst_n <= 1'b0;
    rom_loaded <= 1'b0;
    awvalid <= 1'b0;
    awaddr <= '0;
    wvalid <= 1'b0;
    wstrb <= '0;
    wdata <= '0;
    bready <= 1'b0;
    arvalid <= 1'b0;
    araddr <= '0;
    rready <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_values();
    finish_test("reset_values");
    test_control_rw();
    finish_test("control_rw");
    test_loader_pulse();
    finish_test("loader_pulse");
    test_status_version();
    finish_test("status_version");
    test_bad_address();
    finish_test("bad_address");
    test_backpressure();
    finish_test("backpressure");
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verilog
verilog/axi_nes_pkg.sv
verilog/axi_lite_reg_slave.sv
verilog/nes_ctrl_regs.sv
verilog/axi_nes.sv
test/axi_nes_checker.sv
test/tb_axi_nes.sv

// File: Bender.yml
package:
  name: axi_nes

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/axi_nes_pkg.sv
      - verilog/axi_lite_reg_slave.sv
      - verilog/nes_ctrl_regs.sv
      - verilog/axi_nes.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/axi_nes_checker.sv
      - test/tb_axi_nes.sv
